// File: vlog.f
fetch_pkg.sv
pc_gen.sv
btb.sv
fetch_apb.sv
fetch_top.sv
tb_imem.sv
tb_fetch.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f vlog.f --top-module tb_fetch -o tb_fetch &&
  ./obj_dir/tb_fetch | tee /dev/stderr | grep -qx "No errors" &&
  echo "PASS" ||
  { echo "FAIL"; exit 1; }

// File: tb_fetch.sv
module tb_fetch import fetch_pkg::*; ();

  // pslverr address inside the range of random branch targets
  localparam logic [xlen-1:0] err_addr = pc_reset_addr + 32'h40;
  localparam int accept_goal = 400;

  logic                clk = 1'b0;
  logic                rst;
  logic                flush_i;
  logic                trap_valid_i;
  logic [xlen-1:0]     trap_pc_i;
  logic                branch_valid_i;
  logic [xlen-1:0]     branch_pc_i;
  logic [xlen-1:0]     branch_src_pc_i;
  logic                psel_o;
  logic                penable_o;
  logic [xlen-1:0]     paddr_o;
  logic                pready_i;
  logic [inst_len-1:0] prdata_i;
  logic                pslverr_i;
  logic                inst_valid_o;
  logic [inst_len-1:0] inst_o;
  logic [xlen-1:0]     inst_pc_o;
  logic                inst_fault_o;
  logic                inst_ready_i;

  // reference pc and btb copy
  logic [xlen-1:0]        model_pc;
  logic [btb_entries-1:0] bt_valid;
  logic [xlen-1:0]        bt_src [btb_entries];
  logic [xlen-1:0]        bt_tgt [btb_entries];

  // what the previous cycle demands of this one
  logic                   p_busy;
  logic                   p_setup;
  logic                   p_wait;
  logic [xlen-1:0]        p_paddr;
  logic                   p_hold;
  logic                   p_drop;
  logic [inst_len+xlen:0] p_out;

  logic [31:0] rng;
  logic [2:0]  ready_left;
  int          accepted = 0;
  int          mismatches = 0;
  int          timeouts;

  fetch_top dut (.*);

  tb_imem #(.err_addr(err_addr)) imem (
    .clk       (clk),
    .psel_i    (psel_o),
    .penable_i (penable_o),
    .paddr_i   (paddr_o),
    .pready_o  (pready_i),
    .prdata_o  (prdata_i),
    .pslverr_o (pslverr_i)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // 32 bits starting at a halfword from the slave's array
  function automatic logic [inst_len-1:0] mem_word(input logic [xlen-1:0] addr);
    logic [9:0] lo;
    logic [9:0] hi;
    lo = addr[10:1];
    hi = lo + 10'd1;
    return {imem.mem[hi], imem.mem[lo]};
  endfunction

  task automatic flag_error(input string msg);
    mismatches++;
    $display("Mismatch at time %0t: %s", $time, msg);
  endtask

  // random redirects and ready stretches for one cycle
  task automatic drive_cycle();
    rng = xorshift32(rng);
    if (ready_left == 3'd0) begin
      inst_ready_i = rng[0] | rng[1];
      ready_left   = rng[4:2];
    end else begin
      ready_left = ready_left - 3'd1;
    end
    flush_i        = 1'b0;
    trap_valid_i   = 1'b0;
    branch_valid_i = 1'b0;
    // targets low in memory so later flow runs back over old sources
    branch_pc_i     = pc_reset_addr + xlen'({rng[10:5], 1'b0});
    trap_pc_i       = pc_reset_addr + 32'h100 + xlen'({rng[15:11], 1'b0});
    branch_src_pc_i = model_pc;
    case (rng[31:25])
      7'd0, 7'd1, 7'd2, 7'd3: branch_valid_i = 1'b1;
      7'd4: trap_valid_i = 1'b1;
      7'd5: begin
        trap_valid_i   = 1'b1;
        branch_valid_i = 1'b1;
      end
      7'd6: begin
        flush_i      = 1'b1;
        trap_valid_i = 1'b1;
      end
      default: ;
    endcase
  endtask

  // checks and reference model sampled at the falling edge
  always @(negedge clk) begin
    logic [xlen-1:0]      next_pc;
    logic [inst_len-1:0]  word;
    logic [btb_idx_w-1:0] idx;
    logic [btb_idx_w-1:0] widx;
    logic                 kill;
    kill = flush_i | trap_valid_i | branch_valid_i;
    if (rst) begin
      assert (!psel_o && !penable_o && !inst_valid_o) else flag_error("active output in reset");
      model_pc = pc_reset_addr;
      bt_valid = '0;
    end else begin
      // apb rules
      assert (!p_busy || (psel_o && paddr_o == p_paddr))
        else flag_error("apb transfer abandoned or paddr moved");
      assert (!p_setup || penable_o) else flag_error("no access cycle after setup");
      assert (!p_wait || penable_o) else flag_error("access ended without pready");
      assert (psel_o || !penable_o) else flag_error("penable without psel");
      assert (!(psel_o && inst_valid_o)) else flag_error("apb started while instruction held");
      assert (!(psel_o && !penable_o) || paddr_o == model_pc)
        else flag_error("setup paddr differs from expected pc");
      // downstream hold and release
      assert (!p_hold || (inst_valid_o && {inst_o, inst_pc_o, inst_fault_o} == p_out))
        else flag_error("held instruction changed under back-pressure");
      assert (!p_drop || !inst_valid_o) else flag_error("instruction not released");
      assert (!inst_valid_o || inst_pc_o == model_pc) else flag_error("inst_pc_o wrong");
      assert (!inst_valid_o || inst_o == mem_word(model_pc)) else flag_error("inst_o wrong");
      assert (!inst_valid_o || inst_fault_o == (model_pc == err_addr))
        else flag_error("inst_fault_o wrong");
      next_pc = model_pc;
      idx     = model_pc[btb_idx_w:1];
      word    = mem_word(model_pc);
      if (inst_valid_o && inst_ready_i) begin
        accepted++;
        if (bt_valid[idx] && bt_src[idx] == model_pc) begin
          next_pc = bt_tgt[idx];
        end else if (word[1:0] == 2'b11) begin
          next_pc = model_pc + 32'd4;
        end else begin
          next_pc = model_pc + 32'd2;
        end
      end
      // lowest redirect first and highest lands last
      if (branch_valid_i) next_pc = branch_pc_i;
      if (trap_valid_i) next_pc = trap_pc_i;
      if (flush_i) next_pc = pc_reset_addr;
      // every branch trains even when overridden
      if (branch_valid_i) begin
        widx         = branch_src_pc_i[btb_idx_w:1];
        bt_valid[widx] = 1'b1;
        bt_src[widx] = branch_src_pc_i;
        bt_tgt[widx] = branch_pc_i;
      end
      model_pc = next_pc;
    end
    p_busy  = psel_o && !(penable_o && pready_i);
    p_setup = psel_o && !penable_o;
    p_wait  = penable_o && !pready_i;
    p_paddr = paddr_o;
    p_hold  = inst_valid_o && !inst_ready_i && !kill;
    p_drop  = inst_valid_o && (inst_ready_i || kill);
    p_out   = {inst_o, inst_pc_o, inst_fault_o};
  end

  initial begin
    int cyc;
    rst             = 1'b1;
    flush_i         = 1'b0;
    trap_valid_i    = 1'b0;
    trap_pc_i       = '0;
    branch_valid_i  = 1'b0;
    branch_pc_i     = '0;
    branch_src_pc_i = '0;
    inst_ready_i    = 1'b0;
    rng             = 32'hc69eb281;
    ready_left      = '0;
    timeouts        = 0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    // first fetch sits in hold until ready
    cyc = 0;
    while (!inst_valid_o && cyc < 50) begin
      @(posedge clk);
      #1;
      cyc++;
    end
    if (!inst_valid_o) begin
      $display("Timeout: no instruction came out after reset");
      timeouts++;
    end else begin
      cyc = 0;
      while (accepted < accept_goal && cyc < 20000) begin
        drive_cycle();
        @(posedge clk);
        #1;
        cyc++;
      end
      if (accepted < accept_goal) begin
        $display("Timeout: only %0d instructions were accepted", accepted);
        timeouts++;
      end
    end
    $display("accepted %0d, mismatches %0d, timeouts %0d", accepted, mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: tb_imem.sv
module tb_imem import fetch_pkg::*; #(
  // the one address that answers with pslverr
  parameter logic [xlen-1:0] err_addr = pc_reset_addr
) (
  input  logic                clk,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic [xlen-1:0]     paddr_i,
  output logic                pready_o,
  output logic [inst_len-1:0] prdata_o,
  output logic                pslverr_o
);

  // 2 KB of halfwords, higher address bits alias
  localparam int unsigned mem_hw = 1024;

  logic [15:0] mem [mem_hw];
  logic [31:0] rng;
  logic [1:0]  wait_left;
  logic [9:0]  lo_idx;
  logic [9:0]  hi_idx;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  initial begin
    rng    = 32'hc69eb281;
    lo_idx = '0;
    // roughly half the halfwords open a 32 bit encoding
    repeat (mem_hw) begin
      rng         = xorshift32(rng);
      mem[lo_idx] = rng[16] ? {rng[15:2], 2'b11} : rng[15:0];
      lo_idx      = lo_idx + 10'd1;
    end
    pready_o  = 1'b0;
    prdata_o  = '0;
    pslverr_o = 1'b0;
    wait_left = '0;
    forever begin
      @(posedge clk);
      #1;
      pready_o  = 1'b0;
      pslverr_o = 1'b0;
      if (psel_i && !penable_i) begin
        // setup picks 0 to 3 wait states
        rng       = xorshift32(rng);
        wait_left = rng[1:0];
      end else if (psel_i && penable_i) begin
        if (wait_left == 2'd0) begin
          // 32 bits from any halfword
          lo_idx    = paddr_i[10:1];
          hi_idx    = lo_idx + 10'd1;
          prdata_o  = {mem[hi_idx], mem[lo_idx]};
          pslverr_o = (paddr_i == err_addr);
          pready_o  = 1'b1;
        end else begin
          wait_left = wait_left - 2'd1;
        end
      end
    end
  end

endmodule

// File: fetch_top.sv
module fetch_top import fetch_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  // redirects
  input  logic                flush_i,
  input  logic                trap_valid_i,
  input  logic [xlen-1:0]     trap_pc_i,
  input  logic                branch_valid_i,
  input  logic [xlen-1:0]     branch_pc_i,
  input  logic [xlen-1:0]     branch_src_pc_i,
  // apb master
  output logic                psel_o,
  output logic                penable_o,
  output logic [xlen-1:0]     paddr_o,
  input  logic                pready_i,
  input  logic [inst_len-1:0] prdata_i,
  input  logic                pslverr_i,
  // instruction output
  output logic                inst_valid_o,
  output logic [inst_len-1:0] inst_o,
  output logic [xlen-1:0]     inst_pc_o,
  output logic                inst_fault_o,
  input  logic                inst_ready_i
);

  // pc and redirect kill
  logic [xlen-1:0] pc;
  logic            kill;

  // sequential advance from the fetch master
  logic            advance;
  logic            is_compressed;

  // prediction for the current pc
  logic            pred_hit;
  logic [xlen-1:0] pred_target;

  pc_gen u_pc_gen (
    .clk             (clk),
    .rst             (rst),
    .flush_i         (flush_i),
    .trap_valid_i    (trap_valid_i),
    .trap_pc_i       (trap_pc_i),
    .branch_valid_i  (branch_valid_i),
    .branch_pc_i     (branch_pc_i),
    .advance_i       (advance),
    .is_compressed_i (is_compressed),
    .pred_hit_i      (pred_hit),
    .pred_target_i   (pred_target),
    .pc_o            (pc),
    .kill_o          (kill)
  );

  // trained by every resolved branch
  btb u_btb (
    .clk            (clk),
    .rst            (rst),
    .pc_i           (pc),
    .train_i        (branch_valid_i),
    .train_src_i    (branch_src_pc_i),
    .train_target_i (branch_pc_i),
    .hit_o          (pred_hit),
    .target_o       (pred_target)
  );

  fetch_apb u_fetch_apb (
    .clk             (clk),
    .rst             (rst),
    .pc_i            (pc),
    .kill_i          (kill),
    .psel_o          (psel_o),
    .penable_o       (penable_o),
    .paddr_o         (paddr_o),
    .pready_i        (pready_i),
    .prdata_i        (prdata_i),
    .pslverr_i       (pslverr_i),
    .inst_valid_o    (inst_valid_o),
    .inst_o          (inst_o),
    .inst_pc_o       (inst_pc_o),
    .inst_fault_o    (inst_fault_o),
    .inst_ready_i    (inst_ready_i),
    .advance_o       (advance),
    .is_compressed_o (is_compressed)
  );

endmodule

// File: fetch_apb.sv
module fetch_apb import fetch_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  // current fetch pc and redirect kill
  input  logic [xlen-1:0]     pc_i,
  input  logic                kill_i,
  // apb master toward instruction memory
  output logic                psel_o,
  output logic                penable_o,
  output logic [xlen-1:0]     paddr_o,
  input  logic                pready_i,
  input  logic [inst_len-1:0] prdata_i,
  input  logic                pslverr_i,
  // instruction output, valid/ready
  output logic                inst_valid_o,
  output logic [inst_len-1:0] inst_o,
  output logic [xlen-1:0]     inst_pc_o,
  output logic                inst_fault_o,
  input  logic                inst_ready_i,
  // back to the pc block
  output logic                advance_o,
  output logic                is_compressed_o
);

  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_access,
    st_hold
  } state_t;

  state_t state_q;
  state_t state_d;

  // transfer in flight was overtaken by a redirect
  logic stale_q;
  logic stale_d;

  // address and captured payload
  logic [xlen-1:0]     paddr_q;
  logic [inst_len-1:0] inst_q;
  logic [xlen-1:0]     inst_pc_q;
  logic                fault_q;

  logic start;
  logic done;
  logic capture;
  logic accept;

  // new fetch only from idle and only with a settled pc
  assign start = (state_q == st_idle) & ~kill_i;

  // apb completion
  assign done = (state_q == st_access) & pready_i;

  // good data only when nothing killed the transfer
  assign capture = done & ~stale_q & ~kill_i;

  // downstream takes the held word
  assign accept = (state_q == st_hold) & inst_ready_i;

  always_comb begin
    state_d = state_q;
    stale_d = stale_q;
    case (state_q)
      st_idle: begin
        stale_d = 1'b0;
        if (start) begin
          state_d = st_setup;
        end
      end
      st_setup: begin
        // transfer keeps going, just remember it is dead
        if (kill_i) begin
          stale_d = 1'b1;
        end
        state_d = st_access;
      end
      st_access: begin
        if (pready_i) begin
          stale_d = 1'b0;
          if (capture) begin
            state_d = st_hold;
          end else begin
            state_d = st_idle;
          end
        end else if (kill_i) begin
          stale_d = 1'b1;
        end
      end
      st_hold: begin
        // a redirect drops the held word, acceptance releases it
        if (kill_i || inst_ready_i) begin
          state_d = st_idle;
        end
      end
      default: begin
        state_d = st_idle;
        stale_d = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
      stale_q <= 1'b0;
    end else begin
      state_q <= state_d;
      stale_q <= stale_d;
    end
  end

  // address latched at issue, stable through completion
  always_ff @(posedge clk) begin
    if (start) begin
      paddr_q <= pc_i;
    end
  end

  // payload held under back-pressure
  always_ff @(posedge clk) begin
    if (capture) begin
      inst_q    <= prdata_i;
      inst_pc_q <= paddr_q;
      fault_q   <= pslverr_i;
    end
  end

  assign psel_o    = (state_q == st_setup) | (state_q == st_access);
  assign penable_o = (state_q == st_access);
  assign paddr_o   = paddr_q;

  assign inst_valid_o = (state_q == st_hold);
  assign inst_o       = inst_q;
  assign inst_pc_o    = inst_pc_q;
  assign inst_fault_o = fault_q;

  // one cycle pulse per accepted word
  assign advance_o = accept;

  // rvc when the low two bits are not 2'b11
  assign is_compressed_o = (inst_q[1:0] != 2'b11);

endmodule

// File: btb.sv
module btb import fetch_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  // lookup side
  input  logic [xlen-1:0] pc_i,
  // training from resolved branches
  input  logic            train_i,
  input  logic [xlen-1:0] train_src_i,
  input  logic [xlen-1:0] train_target_i,
  output logic            hit_o,
  output logic [xlen-1:0] target_o
);

  // per entry state
  logic [btb_entries-1:0] valid_q;
  logic [btb_tag_w-1:0]   tag_q    [btb_entries];
  logic [xlen-1:0]        target_q [btb_entries];

  // lookup fields
  logic [btb_idx_w-1:0]   rd_idx;
  logic [btb_tag_w-1:0]   rd_tag;

  // training fields
  logic [btb_idx_w-1:0]   wr_idx;
  logic [btb_tag_w-1:0]   wr_tag;

  // index skips pc bit 0
  assign rd_idx = pc_i[btb_idx_w:1];
  assign rd_tag = pc_i[xlen-1:btb_idx_w+1];

  assign wr_idx = train_src_i[btb_idx_w:1];
  assign wr_tag = train_src_i[xlen-1:btb_idx_w+1];

  // combinational lookup
  // no write bypass, a new entry shows from the next cycle
  always_comb begin
    hit_o    = 1'b0;
    target_o = target_q[rd_idx];
    if (valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag)) begin
      hit_o = 1'b1;
    end
  end

  // valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (train_i) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // tag and target storage
  // training simply overwrites whatever sits at the index
  always_ff @(posedge clk) begin
    if (train_i) begin
      tag_q[wr_idx]    <= wr_tag;
      target_q[wr_idx] <= train_target_i;
    end
  end

endmodule

// File: pc_gen.sv
module pc_gen import fetch_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  // redirect sources, highest priority first
  input  logic            flush_i,
  input  logic            trap_valid_i,
  input  logic [xlen-1:0] trap_pc_i,
  input  logic            branch_valid_i,
  input  logic [xlen-1:0] branch_pc_i,
  // sequential flow from the fetch master
  input  logic            advance_i,
  input  logic            is_compressed_i,
  // prediction for the current pc
  input  logic            pred_hit_i,
  input  logic [xlen-1:0] pred_target_i,
  output logic [xlen-1:0] pc_o,
  output logic            kill_o
);

  logic [xlen-1:0] pc_q;
  logic [xlen-1:0] pc_d;
  logic [xlen-1:0] pc_step;
  logic [xlen-1:0] pc_seq;
  logic            redirect;
  logic            pc_we;

  // any redirect overrides the sequential flow
  assign redirect = flush_i | trap_valid_i | branch_valid_i;

  // halfword step for compressed, word step otherwise
  assign pc_step = is_compressed_i ? xlen'(2) : xlen'(4);
  assign pc_seq  = pc_q + pc_step;

  // next pc by priority
  always_comb begin
    pc_d = pc_q;
    if (flush_i) begin
      pc_d = pc_reset_addr;
    end else if (trap_valid_i) begin
      pc_d = trap_pc_i;
    end else if (branch_valid_i) begin
      pc_d = branch_pc_i;
    end else if (advance_i) begin
      // predicted target wins over fall through
      if (pred_hit_i) begin
        pc_d = pred_target_i;
      end else begin
        pc_d = pc_seq;
      end
    end
  end

  // pc only moves on a redirect or an accepted instruction
  // otherwise it holds, which is the stall
  assign pc_we = redirect | advance_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= pc_reset_addr;
    end else if (pc_we) begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;

  // tells the fetch master its current or held fetch is stale
  assign kill_o = redirect;

endmodule

// File: fetch_pkg.sv
package fetch_pkg;

  // address and pc width
  localparam int unsigned xlen = 32;

  // fetched instruction word, always a full 32 bit read
  localparam int unsigned inst_len = 32;

  // boot vector, also the flush target
  localparam logic [xlen-1:0] pc_reset_addr = 32'h8000_0000;

  // branch target buffer geometry
  // direct mapped, indexed by pc[btb_idx_w:1]
  localparam int unsigned btb_entries = 8;
  localparam int unsigned btb_idx_w = 3;

  // tag covers the pc bits above the index
  // bit 0 of a pc is always zero and is not kept
  localparam int unsigned btb_tag_w = xlen - btb_idx_w - 1;

endpackage
